// File: rv_lsu.f
hdl/lsu_pkg.sv
hdl/lsu_store_fmt.sv
hdl/lsu_load_align.sv
hdl/lsu_ctrl.sv
hdl/lsu_dmem.sv
hdl/lsu_top.sv
test/lsu_props.sv
test/lsu_tb.sv

// File: run.sh
#!/bin/sh
# Verilator build and run of the LSU regression

cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert --top-module lsu_tb \
    -Mdir "$OBJ_DIR" -o lsu_sim -f rv_lsu.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$OBJ_DIR/lsu_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Regression passed$" "$LOG"; then
    exit 0
fi

echo "No pass line found in $LOG"
exit 1

// File: test/lsu_tb.sv
/* LSU testbench: clock, reset, LFSR data, stimulus table,
   byte-array reference memory, checks and timeout */
`timescale 1ns/1ps
`default_nettype none

module lsu_tb;
    import lsu_pkg::*;

    localparam int DMEM_WORDS  = 256;
    localparam int MEM_BYTES   = DMEM_WORDS * 4;
    localparam int RST_CYCLES  = 16;
    localparam int STIM_N      = 38;
    localparam int CYCLE_LIMIT = STIM_N * 8 + RST_CYCLES;

    localparam logic [1:0] TAB = 2'd0;          // Offset from table
    localparam logic [1:0] RND = 2'd1;          // Fresh random word offset
    localparam logic [1:0] PRV = 2'd2;          // Offset of previous entry

    typedef struct packed {
        lsu_op_e     op;
        logic [31:0] base;
        logic [31:0] offset;
        logic [1:0]  ofs_mode;                  // TAB, RND or PRV
        logic        hold;                      // Keep valid high while busy
        logic        exp_we;                    // Expected rd_we
    } stim_t;

    logic        clk;
    logic        rst_n;
    logic        req_valid;
    lsu_req_t    req;
    logic        busy;
    logic        rsp_valid;
    lsu_rsp_t    rsp;
    logic [31:0] lfsr_q = 32'he61a8e1f;         // Seed
    logic [7:0]  ref_mem [MEM_BYTES];           // Byte-wide model of memory
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;

    stim_t stim_tbl [STIM_N] = '{
        // Word stores to random addresses, read back
        '{LSU_SW,  32'h0000_0000, 32'h0000_0000, RND, 1'b0, 1'b0},
        '{LSU_LW,  32'h0000_0000, 32'h0000_0000, PRV, 1'b0, 1'b1},
        '{LSU_SW,  32'h0000_0000, 32'h0000_0000, RND, 1'b0, 1'b0},
        '{LSU_LW,  32'h0000_0000, 32'h0000_0000, PRV, 1'b1, 1'b1},
        '{LSU_SW,  32'h0000_0000, 32'h0000_0000, RND, 1'b0, 1'b0},
        '{LSU_LW,  32'h0000_0000, 32'h0000_0000, PRV, 1'b0, 1'b1},
        // Byte stores in each lane
        '{LSU_SB,  32'h0000_0040, 32'h0000_0000, TAB, 1'b0, 1'b0},
        '{LSU_LW,  32'h0000_0040, 32'h0000_0000, TAB, 1'b0, 1'b1},
        '{LSU_LB,  32'h0000_0040, 32'h0000_0000, TAB, 1'b0, 1'b1},
        '{LSU_LBU, 32'h0000_0040, 32'h0000_0000, TAB, 1'b0, 1'b1},
        '{LSU_SB,  32'h0000_0040, 32'h0000_0001, TAB, 1'b1, 1'b0},
        '{LSU_LW,  32'h0000_0040, 32'h0000_0001, TAB, 1'b0, 1'b1},
        '{LSU_LB,  32'h0000_0040, 32'h0000_0001, TAB, 1'b0, 1'b1},
        '{LSU_LBU, 32'h0000_0040, 32'h0000_0001, TAB, 1'b0, 1'b1},
        '{LSU_SB,  32'h0000_0040, 32'h0000_0002, TAB, 1'b0, 1'b0},
        '{LSU_LW,  32'h0000_0040, 32'h0000_0002, TAB, 1'b0, 1'b1},
        '{LSU_LB,  32'h0000_0040, 32'h0000_0002, TAB, 1'b0, 1'b1},
        '{LSU_LBU, 32'h0000_0040, 32'h0000_0002, TAB, 1'b0, 1'b1},
        '{LSU_SB,  32'h0000_0040, 32'h0000_0003, TAB, 1'b0, 1'b0},
        '{LSU_LW,  32'h0000_0040, 32'h0000_0003, TAB, 1'b0, 1'b1},
        '{LSU_LB,  32'h0000_0040, 32'h0000_0003, TAB, 1'b1, 1'b1},
        '{LSU_LBU, 32'h0000_0040, 32'h0000_0003, TAB, 1'b0, 1'b1},
        // Halfword stores in both halves
        '{LSU_SH,  32'h0000_0080, 32'h0000_0000, TAB, 1'b0, 1'b0},
        '{LSU_LH,  32'h0000_0080, 32'h0000_0000, TAB, 1'b0, 1'b1},
        '{LSU_LHU, 32'h0000_0080, 32'h0000_0001, TAB, 1'b0, 1'b1},
        '{LSU_LW,  32'h0000_0080, 32'h0000_0000, TAB, 1'b0, 1'b1},
        '{LSU_SH,  32'h0000_0080, 32'h0000_0002, TAB, 1'b1, 1'b0},
        '{LSU_LH,  32'h0000_0080, 32'h0000_0003, TAB, 1'b0, 1'b1},
        '{LSU_LHU, 32'h0000_0080, 32'h0000_0002, TAB, 1'b0, 1'b1},
        '{LSU_LW,  32'h0000_0080, 32'h0000_0001, TAB, 1'b0, 1'b1},
        // Negative offsets, 32-bit wrap and depth wrap
        '{LSU_SW,  32'h0000_0110, 32'hFFFF_FFF8, TAB, 1'b1, 1'b0},
        '{LSU_LW,  32'h0000_0100, 32'h0000_0008, TAB, 1'b0, 1'b1},
        '{LSU_SW,  32'h0000_0400, 32'h0000_000C, TAB, 1'b0, 1'b0},
        '{LSU_LW,  32'h0000_0000, 32'h0000_000C, TAB, 1'b0, 1'b1},
        '{LSU_LH,  32'hFFFF_FFFC, 32'h0000_0010, TAB, 1'b0, 1'b1},
        '{LSU_SB,  32'h8000_0000, 32'h8000_0021, TAB, 1'b0, 1'b0},
        '{LSU_LBU, 32'h0000_0021, 32'h0000_0000, TAB, 1'b1, 1'b1},
        '{LSU_LW,  32'h0000_0020, 32'hFFFF_FC00, TAB, 1'b0, 1'b1}
    };

    lsu_top #(
        .DMEM_WORDS (DMEM_WORDS)
    ) dut_i (
        .clk_i       (clk),
        .rst_n_i     (rst_n),
        .req_valid_i (req_valid),
        .req_i       (req),
        .busy_o      (busy),
        .rsp_valid_o (rsp_valid),
        .rsp_o       (rsp)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;                  // 4 ns period
    end

////////////////////////////////////////////////////////////////////////////
// Helpers
////////////////////////////////////////////////////////////////////////////

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);         // One step per bit
            v      = {v[30:0], lfsr_q[0]};
        end
    endtask

    // Little-endian load from the byte model, address wraps at the depth
    function automatic logic [31:0] ref_load(input lsu_op_e op, input logic [31:0] a);
        int          bi;
        int          hi;
        int          wi;
        logic [7:0]  b;
        logic [15:0] h;
        bi = int'(a % MEM_BYTES);
        hi = bi - (bi % 2);                     // Halfword start
        wi = bi - (bi % 4);                     // Word start
        b  = ref_mem[bi];
        h  = {ref_mem[hi + 1], ref_mem[hi]};
        case (op)
            LSU_LB:  return {{24{b[7]}}, b};
            LSU_LBU: return {24'h000000, b};
            LSU_LH:  return {{16{h[15]}}, h};
            LSU_LHU: return {16'h0000, h};
            default: return {ref_mem[wi + 3], ref_mem[wi + 2], ref_mem[wi + 1], ref_mem[wi]};
        endcase
    endfunction

    task automatic ref_store(input lsu_op_e op, input logic [31:0] a, input logic [31:0] d);
        int bi;
        int hi;
        int wi;
        bi = int'(a % MEM_BYTES);
        hi = bi - (bi % 2);
        wi = bi - (bi % 4);
        case (op)
            LSU_SB: begin
                ref_mem[bi] = d[7:0];
            end
            LSU_SH: begin
                ref_mem[hi]     = d[7:0];
                ref_mem[hi + 1] = d[15:8];
            end
            default: begin
                for (int k = 0; k < 4; k++) begin
                    ref_mem[wi + k] = d[8*k +: 8];
                end
            end
        endcase
    endtask

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("** Error @ %0t ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

////////////////////////////////////////////////////////////////////////////
// Stimulus
////////////////////////////////////////////////////////////////////////////

    initial begin
        stim_t       s;
        logic [31:0] ofs;
        logic [31:0] wd;
        logic [31:0] last_ofs;
        logic [31:0] addr;
        logic [31:0] exp_data;
        logic        was_busy;
        int          lat;
        rst_n     = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        last_ofs  = '0;
        for (int i = 0; i < MEM_BYTES; i++) begin
            ref_mem[i] = 8'h00;                 // DUT memory starts cleared
        end
        repeat (RST_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        repeat (4) begin                        // Idle after reset
            @(negedge clk);
            check_val("busy_o", 32'(busy), 32'h0);
            check_val("rsp_valid_o", 32'(rsp_valid), 32'h0);
            check_val("rsp_o.rd_we", 32'(rsp.rd_we), 32'h0);
        end
        for (int i = 0; i < STIM_N; i++) begin
            s = stim_tbl[i];
            take_bits(32, wd);
            case (s.ofs_mode)
                RND: begin
                    take_bits(10, ofs);
                    ofs = ofs << 2;             // Word aligned, may pass the depth
                end
                PRV: ofs = last_ofs;
                default: ofs = s.offset;
            endcase
            last_ofs = ofs;
            addr     = s.base + ofs;            // 32-bit wrap
            @(posedge clk);
            req_valid <= 1'b1;
            req       <= '{op: s.op, base: s.base, offset: ofs, wdata: wd};
            // Accept on first edge after a cycle with busy low
            do begin
                @(negedge clk);
                was_busy = busy;
                @(posedge clk);
            end while (was_busy);
            if (!s.hold) begin
                req_valid <= 1'b0;
            end
            lat = 0;                            // Edges since acceptance
            @(negedge clk);
            while (!rsp_valid) begin
                check_val("busy_o", 32'(busy), 32'h1);  // Still in flight
                @(posedge clk);
                lat++;
                if (lat == 2) begin
                    req_valid <= 1'b0;          // Release held request
                end
                @(negedge clk);
            end
            if (s.op inside {LSU_LB, LSU_LBU, LSU_LH, LSU_LHU, LSU_LW}) begin
                exp_data = ref_load(s.op, addr);
            end else begin
                exp_data = 32'h0;
                ref_store(s.op, addr, wd);
            end
            check_val("response latency", 32'(lat), 32'd2);
            check_val("rsp_o.rd_we", 32'(rsp.rd_we), 32'(s.exp_we));
            check_val("rsp_o.rd_data", rsp.rd_data, exp_data);
            @(negedge clk);                     // One response, no second accept
            check_val("rsp_valid_o", 32'(rsp_valid), 32'h0);
            check_val("busy_o", 32'(busy), 32'h0);
        end
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, the DUT stopped responding", cycles);
        $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: test/lsu_props.sv
/* Concurrent checks on the Wishbone bus and the response pulse,
   bound into the LSU top level */
`timescale 1ns/1ps
`default_nettype none

module lsu_props (
    input logic              clk_i,
    input logic              rst_n_i,
    input lsu_pkg::wb_m2s_t  m2s_i,             // Master side of the bus
    input lsu_pkg::wb_s2m_t  s2m_i,             // Slave side of the bus
    input logic              rsp_valid_i,
    input lsu_pkg::lsu_rsp_t rsp_i
);

    stb_has_cyc: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        m2s_i.stb |-> m2s_i.cyc)
        else $error("stb high outside a bus cycle");

    ack_single: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        s2m_i.ack |=> !s2m_i.ack)               // One-cycle ack only
        else $error("ack high two cycles in a row");

    rsp_after_ack: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        s2m_i.ack |=> rsp_valid_i)
        else $error("no response in the cycle after ack");

    rsp_needs_ack: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        rsp_valid_i |-> $past(s2m_i.ack))
        else $error("response without ack in the cycle before");

    // Master holds address phase until ack
    adr_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (m2s_i.stb && !s2m_i.ack) |=> ($stable(m2s_i.sel) && $stable(m2s_i.adr)))
        else $error("sel or adr changed while waiting for ack");

    store_rsp_zero: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (rsp_valid_i && !rsp_i.rd_we) |-> (rsp_i.rd_data == 32'h0))
        else $error("store response carries data");

endmodule

bind lsu_top lsu_props props_i (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .m2s_i       (bus_m2s),
    .s2m_i       (bus_s2m),
    .rsp_valid_i (rsp_valid_o),
    .rsp_i       (rsp_o)
);

`default_nettype wire

// File: hdl/lsu_top.sv
/* LSU top: control, store formatter, load aligner and data memory */
`timescale 1ns/1ps
`default_nettype none

module lsu_top #(
    parameter int DMEM_WORDS = 256              // Memory depth in words
) (
    input  logic              clk_i,
    input  logic              rst_n_i,          // Sync, active low
    input  logic              req_valid_i,      // Request present
    input  lsu_pkg::lsu_req_t req_i,            // Request fields
    output logic              busy_o,           // Request ignored while high
    output logic              rsp_valid_o,      // Response pulse
    output lsu_pkg::lsu_rsp_t rsp_o             // Response payload
);
    import lsu_pkg::*;

    wb_m2s_t     fmt_wb;                        // Formatter to control
    wb_m2s_t     bus_m2s;                       // Master to memory
    wb_s2m_t     bus_s2m;                       // Memory to master
    lsu_op_e     ld_op;                         // Held op
    logic [1:0]  ld_addr_lo;                    // Held byte offset
    logic [31:0] ld_data;                       // Aligned read data

    lsu_store_fmt store_fmt_i (
        .req_i (req_i),
        .wb_o  (fmt_wb)
    );

    lsu_ctrl ctrl_i (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .req_valid_i (req_valid_i),
        .req_i       (req_i),
        .fmt_i       (fmt_wb),
        .wb_o        (bus_m2s),
        .wb_i        (bus_s2m),
        .ld_data_i   (ld_data),
        .op_o        (ld_op),
        .addr_lo_o   (ld_addr_lo),
        .busy_o      (busy_o),
        .rsp_valid_o (rsp_valid_o),
        .rsp_o       (rsp_o)
    );

    lsu_load_align load_align_i (
        .op_i      (ld_op),
        .addr_lo_i (ld_addr_lo),
        .word_i    (bus_s2m.dat),               // Valid while ack high
        .data_o    (ld_data)
    );

    lsu_dmem #(
        .DMEM_WORDS (DMEM_WORDS)
    ) dmem_i (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .wb_i    (bus_m2s),
        .wb_o    (bus_s2m)
    );

endmodule

`default_nettype wire

// File: hdl/lsu_dmem.sv
/* Data memory: Wishbone classic slave with byte-lane writes,
   registered read data and one-cycle registered ack */
`timescale 1ns/1ps
`default_nettype none

module lsu_dmem #(
    parameter int DMEM_WORDS = 256              // Depth in words, power of two
) (
    input  logic             clk_i,
    input  logic             rst_n_i,           // Clears ack only
    input  lsu_pkg::wb_m2s_t wb_i,              // From master
    output lsu_pkg::wb_s2m_t wb_o               // To master
);

    localparam int IDX_W = $clog2(DMEM_WORDS);  // Word index width

    logic [3:0][7:0]  mem [DMEM_WORDS];         // Byte-addressable words
    logic [IDX_W-1:0] idx;                      // Word index
    logic             hit;                      // New transfer seen
    logic             ack_q;
    logic [31:0]      rdat_q;                   // Read data for ack cycle

    assign idx = wb_i.adr[IDX_W+1:2];           // Upper bits wrap the depth
    assign hit = wb_i.cyc & wb_i.stb & ~ack_q;  // No re-ack while ack high

    // Contents start cleared
    initial begin
        for (int i = 0; i < DMEM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

////////////////////////////////////////////////////////////////////////////
// Acknowledge
////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= hit;                       // High one cycle per transfer
        end
    end

////////////////////////////////////////////////////////////////////////////
// Array access
////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (hit) begin
            rdat_q <= mem[idx];                 // Old word on writes
            if (wb_i.we) begin
                for (int k = 0; k < 4; k++) begin
                    if (wb_i.sel[k]) begin
                        mem[idx][k] <= wb_i.dat[8*k +: 8];  // Lane k under sel
                    end
                end
            end
        end
    end

    assign wb_o = '{ack: ack_q, dat: rdat_q};

endmodule

`default_nettype wire

// File: hdl/lsu_ctrl.sv
/* LSU control: request acceptance, Wishbone classic master cycle,
   response register and busy flag */
`timescale 1ns/1ps
`default_nettype none

module lsu_ctrl (
    input  logic              clk_i,
    input  logic              rst_n_i,          // Sync, active low
    input  logic              req_valid_i,      // Request present
    input  lsu_pkg::lsu_req_t req_i,            // Request fields
    input  lsu_pkg::wb_m2s_t  fmt_i,            // Formatter output
    output lsu_pkg::wb_m2s_t  wb_o,             // To memory
    input  lsu_pkg::wb_s2m_t  wb_i,             // From memory
    input  logic [31:0]       ld_data_i,        // Aligned load data
    output lsu_pkg::lsu_op_e  op_o,             // Held op for aligner
    output logic [1:0]        addr_lo_o,        // Held byte offset
    output logic              busy_o,           // Cycle in flight
    output logic              rsp_valid_o,      // One-cycle response pulse
    output lsu_pkg::lsu_rsp_t rsp_o             // Response payload
);
    import lsu_pkg::*;

    typedef enum logic {
        IDLE,                                   // Waiting for request
        BUS                                     // Classic cycle open
    } state_e;

    state_e      state_q;
    logic        accept;                        // Request taken this edge
    logic        done;                          // Ack seen this edge
    logic        is_load;                       // Held op is a load
    wb_m2s_t     fmt_q;                         // Held bus fields
    lsu_op_e     op_q;
    logic [1:0]  addr_lo_q;
    logic        rsp_valid_q;
    logic        rd_we_q;
    logic [31:0] rd_data_q;

    assign busy_o  = (state_q == BUS);          // Low again in response cycle
    assign accept  = req_valid_i & ~busy_o;
    assign done    = busy_o & wb_i.ack;
    assign is_load = op_q inside {LSU_LB, LSU_LBU, LSU_LH, LSU_LHU, LSU_LW};

////////////////////////////////////////////////////////////////////////////
// FSM and response flags
////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q     <= IDLE;
            rsp_valid_q <= 1'b0;
            rd_we_q     <= 1'b0;
        end else begin
            rsp_valid_q <= done;                // Pulse after ack
            case (state_q)
                IDLE: begin
                    if (accept) begin
                        state_q <= BUS;
                    end
                end
                BUS: begin
                    if (wb_i.ack) begin
                        state_q <= IDLE;        // Drop cyc/stb
                    end
                end
            endcase
            if (done) begin
                rd_we_q <= is_load;             // Stores never write rd
            end
        end
    end

////////////////////////////////////////////////////////////////////////////
// Payload
////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (accept) begin
            fmt_q     <= fmt_i;                 // Stable until ack
            op_q      <= req_i.op;
            addr_lo_q <= fmt_i.adr[1:0];
        end
        if (done) begin
            rd_data_q <= is_load ? ld_data_i : 32'h0;
        end
    end

    always_comb begin
        wb_o     = fmt_q;
        wb_o.cyc = busy_o;                      // Cycle spans the whole BUS state
        wb_o.stb = busy_o;
    end

    assign op_o        = op_q;
    assign addr_lo_o   = addr_lo_q;
    assign rsp_valid_o = rsp_valid_q;
    assign rsp_o       = '{rd_we: rd_we_q, rd_data: rd_data_q};

endmodule

`default_nettype wire

// File: hdl/lsu_load_align.sv
/* Load aligner: picks the addressed byte or halfword of a
   read word and extends it with sign or zeros */
`timescale 1ns/1ps
`default_nettype none

module lsu_load_align (
    input  lsu_pkg::lsu_op_e op_i,              // Load flavour
    input  logic [1:0]       addr_lo_i,         // Byte offset in word
    input  logic [31:0]      word_i,            // Word from memory
    output logic [31:0]      data_o             // Register file value
);
    import lsu_pkg::*;

    lsu_lane_u   lane;                          // Read word by lanes
    logic [7:0]  lane_byte;                     // Addressed byte
    logic [15:0] lane_half;                     // Addressed half

    assign lane      = word_i;
    assign lane_byte = lane.b[addr_lo_i];       // Any of four bytes
    assign lane_half = lane.h[addr_lo_i[1]];    // Bit 0 ignored

////////////////////////////////////////////////////////////////////////////
// Extension
////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (op_i)
            LSU_LB: begin
                data_o = {{24{lane_byte[7]}}, lane_byte};    // Sign
            end
            LSU_LBU: begin
                data_o = {24'h000000, lane_byte};            // Zeros
            end
            LSU_LH: begin
                data_o = {{16{lane_half[15]}}, lane_half};   // Sign
            end
            LSU_LHU: begin
                data_o = {16'h0000, lane_half};              // Zeros
            end
            default: begin
                data_o = word_i;                // LW, stores unused
            end
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/lsu_store_fmt.sv
/* Store formatter: effective address, byte selects and
   lane-replicated store data for one Wishbone transfer */
`timescale 1ns/1ps
`default_nettype none

module lsu_store_fmt (
    input  lsu_pkg::lsu_req_t req_i,            // Incoming request
    output lsu_pkg::wb_m2s_t  wb_o              // Bus fields, cyc/stb left low
);
    import lsu_pkg::*;

    logic [31:0] addr;                          // Effective address
    lsu_lane_u   lane;                          // Store data by lanes
    logic [3:0]  sel;                           // Byte selects
    logic        we;                            // Store flag

    assign addr = req_i.base + req_i.offset;    // Wraps at 32 bits

////////////////////////////////////////////////////////////////////////////
// Lane replication and selects
////////////////////////////////////////////////////////////////////////////

    always_comb begin
        lane = '0;                              // Loads drive no data
        sel  = 4'b0000;
        we   = 1'b0;
        case (req_i.op)
            LSU_SB: begin
                lane.b = {4{req_i.wdata[7:0]}};         // Byte in all lanes
                sel    = 4'b0001 << addr[1:0];          // One-hot by byte offset
                we     = 1'b1;
            end
            LSU_SH: begin
                lane.h = {2{req_i.wdata[15:0]}};        // Half in both halves
                sel    = addr[1] ? 4'b1100 : 4'b0011;   // Bit 0 ignored
                we     = 1'b1;
            end
            LSU_SW: begin
                lane.b = req_i.wdata;                   // Straight through
                sel    = 4'b1111;
                we     = 1'b1;
            end
            default: begin
                lane = '0;                              // Loads and unused codes
            end
        endcase
    end

    // Control module owns cyc and stb
    assign wb_o = '{
        cyc: 1'b0,
        stb: 1'b0,
        we:  we,
        sel: sel,
        adr: addr,                              // Full byte address
        dat: lane
    };

endmodule

`default_nettype wire

// File: hdl/lsu_pkg.sv
/* Load-store unit types: operation enum, request and response structs,
   Wishbone classic master/slave bundles and the data lane union */
`default_nettype none

package lsu_pkg;

////////////////////////////////////////////////////////////////////////////
// Operations
////////////////////////////////////////////////////////////////////////////

    typedef enum logic [3:0] {
        LSU_LB  = 4'h0,                         // Load byte, sign extended
        LSU_LBU = 4'h1,                         // Load byte, zero extended
        LSU_LH  = 4'h2,                         // Load half, sign extended
        LSU_LHU = 4'h3,                         // Load half, zero extended
        LSU_LW  = 4'h4,                         // Load word
        LSU_SB  = 4'h5,                         // Store byte
        LSU_SH  = 4'h6,                         // Store half
        LSU_SW  = 4'h7                          // Store word
    } lsu_op_e;

////////////////////////////////////////////////////////////////////////////
// Request and response
////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        lsu_op_e     op;                        // What to do
        logic [31:0] base;                      // Base register value
        logic [31:0] offset;                    // Immediate, two's complement
        logic [31:0] wdata;                     // Store data, low bits used for SB/SH
    } lsu_req_t;

    typedef struct packed {
        logic        rd_we;                     // Register file write, loads only
        logic [31:0] rd_data;                   // Aligned load result
    } lsu_rsp_t;

////////////////////////////////////////////////////////////////////////////
// Wishbone classic
////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic        cyc;                       // Bus cycle in progress
        logic        stb;                       // Transfer strobe
        logic        we;                        // Write transfer
        logic [3:0]  sel;                       // Byte lane selects
        logic [31:0] adr;                       // Byte address
        logic [31:0] dat;                       // Write data
    } wb_m2s_t;

    typedef struct packed {
        logic        ack;                       // Transfer done
        logic [31:0] dat;                       // Read data, valid with ack
    } wb_s2m_t;

    // One data word seen as byte lanes or halfword lanes
    typedef union packed {
        logic [3:0][7:0]  b;                    // Byte lanes, b[0] is bits 7:0
        logic [1:0][15:0] h;                    // Half lanes, h[0] is bits 15:0
    } lsu_lane_u;

endpackage

`default_nettype wire
